/* seq_params.svh */
// Sizing of the vector sequencer
// The ID count must be a power of two, and the queue depth must fit in the count type
`ifndef SEQ_PARAMS_SVH
`define SEQ_PARAMS_SVH

////////////////////
// Instruction slots
////////////////////

// In-flight vector instructions, one ID each
`define SEQ_NR_VINSN 8

////////////////////
// Register file
////////////////////

// Architectural vector registers
`define SEQ_NR_VREGS 32

////////////////////
// Execution units
////////////////////

// ALU, load unit, store unit
`define SEQ_NR_UNITS 3
// Instructions each unit may hold at once
`define SEQ_QUEUE_DEPTH 2

`endif

/* seq_isa_pkg.sv */
// Vector opcodes, target units and operand usage
// The opcode set is reduced to one ALU, one load and one store class
`include "seq_params.svh"

package seq_isa_pkg;

  // Opcodes handled by the sequencer
  typedef enum logic [1:0] {
    VADD,
    VMUL,
    VLE,
    VSE
  } vop_e;

  // Units, in the order of the done_valid bits
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  // Vector register index
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;

  ////////////////////
  // Operand decode
  ////////////////////

  function automatic unit_e op_unit(vop_e op);
    unit_e unit;
    case (op)
      VLE:     unit = UNIT_LOAD;
      VSE:     unit = UNIT_STORE;
      default: unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

  // Store data comes in through vs1
  function automatic logic op_uses_vs1(vop_e op);
    return (op == VADD) || (op == VMUL) || (op == VSE);
  endfunction

  function automatic logic op_uses_vs2(vop_e op);
    return (op == VADD) || (op == VMUL);
  endfunction

  // Stores have no destination register
  function automatic logic op_writes_vd(vop_e op);
    return op != VSE;
  endfunction

endpackage

/* seq_ctrl_pkg.sv */
// Sequencer bookkeeping types
// Widths follow the sizes in the params header
`include "seq_params.svh"

package seq_ctrl_pkg;

  ////////////////////
  // Instruction IDs
  ////////////////////

  // One in-flight instruction
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;

  // Bit i stands for instruction ID i
  typedef logic [`SEQ_NR_VINSN-1:0] vid_mask_t;

  ////////////////////
  // Unit queues
  ////////////////////

  // Occupancy 0 up to the full queue depth
  typedef logic [$clog2(`SEQ_QUEUE_DEPTH + 1)-1:0] qcnt_t;

endpackage

/* seq_req_buffer.sv */
// One-entry request buffer on the dispatcher side
// Accepts a new request in the same cycle the held one is popped
`timescale 1ns/10ps

module seq_req_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatcher handshake
  input  logic                req_valid_i,
  input  seq_isa_pkg::vop_e   req_op_i,
  input  seq_isa_pkg::vreg_t  req_vd_i,
  input  seq_isa_pkg::vreg_t  req_vs1_i,
  input  seq_isa_pkg::vreg_t  req_vs2_i,
  output logic                req_ready_o,
  // Held request towards hazard check and issue
  input  logic                pop_i,
  output logic                buf_valid_o,
  output seq_isa_pkg::vop_e   buf_op_o,
  output seq_isa_pkg::vreg_t  buf_vd_o,
  output seq_isa_pkg::vreg_t  buf_vs1_o,
  output seq_isa_pkg::vreg_t  buf_vs2_o
);

  logic fill;

  // Free slot, or the slot drains this cycle
  assign req_ready_o = !buf_valid_o || pop_i;
  assign fill        = req_valid_i && req_ready_o;

  // Slot occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_o <= 1'b0;
    end else if (fill) begin
      buf_valid_o <= 1'b1;
    end else if (pop_i) begin
      buf_valid_o <= 1'b0;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (fill) begin
      buf_op_o  <= req_op_i;
      buf_vd_o  <= req_vd_i;
      buf_vs1_o <= req_vs1_i;
      buf_vs2_o <= req_vs2_i;
    end
  end

endmodule

/* seq_hazard_tracker.sv */
// Last reader and last writer per vector register, as instruction IDs
// Only one reader is kept per register, the newest one
`timescale 1ns/10ps
`include "seq_params.svh"

module seq_hazard_tracker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Buffered request
  input  seq_isa_pkg::vop_e       buf_op_i,
  input  seq_isa_pkg::vreg_t      buf_vd_i,
  input  seq_isa_pkg::vreg_t      buf_vs1_i,
  input  seq_isa_pkg::vreg_t      buf_vs2_i,
  // Issue event and live IDs
  input  logic                    issue_i,
  input  seq_ctrl_pkg::vid_t      issue_vid_i,
  input  seq_ctrl_pkg::vid_mask_t running_i,
  // Dependency masks
  output seq_ctrl_pkg::vid_mask_t haz_vs1_o,
  output seq_ctrl_pkg::vid_mask_t haz_vs2_o,
  output seq_ctrl_pkg::vid_mask_t haz_vd_o
);

  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  // Access lists, IDs and valid bits kept apart
  vid_t                     rd_vid_q [`SEQ_NR_VREGS];
  vid_t                     wr_vid_q [`SEQ_NR_VREGS];
  logic [`SEQ_NR_VREGS-1:0] rd_vld_q, rd_vld_d;
  logic [`SEQ_NR_VREGS-1:0] wr_vld_q, wr_vld_d;
  // Entries whose instruction is still running
  logic [`SEQ_NR_VREGS-1:0] rd_live, wr_live;

  // Drop entries once their ID has retired
  always_comb begin
    for (int r = 0; r < `SEQ_NR_VREGS; r++) begin
      rd_live[r] = rd_vld_q[r] && running_i[rd_vid_q[r]];
      wr_live[r] = wr_vld_q[r] && running_i[wr_vid_q[r]];
    end
  end

  ////////////////////
  // Dependency masks
  ////////////////////

  always_comb begin
    haz_vs1_o = '0;
    haz_vs2_o = '0;
    haz_vd_o  = '0;
    // RAW on the sources
    if (op_uses_vs1(buf_op_i) && wr_live[buf_vs1_i]) begin
      haz_vs1_o[wr_vid_q[buf_vs1_i]] = 1'b1;
    end
    if (op_uses_vs2(buf_op_i) && wr_live[buf_vs2_i]) begin
      haz_vs2_o[wr_vid_q[buf_vs2_i]] = 1'b1;
    end
    if (op_writes_vd(buf_op_i)) begin
      // WAR, the old reader has to get its operand first
      if (rd_live[buf_vd_i]) begin
        haz_vs1_o[rd_vid_q[buf_vd_i]] = 1'b1;
        haz_vs2_o[rd_vid_q[buf_vd_i]] = 1'b1;
      end
      // WAW keeps the write order
      if (wr_live[buf_vd_i]) begin
        haz_vd_o[wr_vid_q[buf_vd_i]] = 1'b1;
      end
    end
  end

  ////////////////////
  // List update
  ////////////////////

  always_comb begin
    rd_vld_d = rd_live;
    wr_vld_d = wr_live;
    if (issue_i) begin
      if (op_uses_vs1(buf_op_i)) rd_vld_d[buf_vs1_i] = 1'b1;
      if (op_uses_vs2(buf_op_i)) rd_vld_d[buf_vs2_i] = 1'b1;
      if (op_writes_vd(buf_op_i)) wr_vld_d[buf_vd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld_q <= '0;
      wr_vld_q <= '0;
    end else begin
      rd_vld_q <= rd_vld_d;
      wr_vld_q <= wr_vld_d;
    end
  end

  // New ID becomes the latest reader or writer
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      if (op_uses_vs1(buf_op_i)) rd_vid_q[buf_vs1_i] <= issue_vid_i;
      if (op_uses_vs2(buf_op_i)) rd_vid_q[buf_vs2_i] <= issue_vid_i;
      if (op_writes_vd(buf_op_i)) wr_vid_q[buf_vd_i] <= issue_vid_i;
    end
  end

endmodule

/* seq_issue_ctrl.sv */
// ID allocation, per-unit queue counters and the issue register
// A retiring ID is free only from the next cycle, a queue slot frees at once
`timescale 1ns/10ps
`include "seq_params.svh"

module seq_issue_ctrl (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Buffered request and its masks
  input  logic                                       buf_valid_i,
  input  seq_isa_pkg::vop_e                          buf_op_i,
  input  seq_isa_pkg::vreg_t                         buf_vd_i,
  input  seq_isa_pkg::vreg_t                         buf_vs1_i,
  input  seq_isa_pkg::vreg_t                         buf_vs2_i,
  input  seq_ctrl_pkg::vid_mask_t                    haz_vs1_i,
  input  seq_ctrl_pkg::vid_mask_t                    haz_vs2_i,
  input  seq_ctrl_pkg::vid_mask_t                    haz_vd_i,
  // Feedback to buffer and tracker
  output logic                                       pop_o,
  output seq_ctrl_pkg::vid_t                         issue_vid_o,
  output seq_ctrl_pkg::vid_mask_t                    running_o,
  // Issue towards the units
  output logic                                       pe_valid_o,
  input  logic                                       pe_ready_i,
  output seq_isa_pkg::vop_e                          pe_op_o,
  output seq_isa_pkg::unit_e                         pe_unit_o,
  output seq_ctrl_pkg::vid_t                         pe_vid_o,
  output seq_isa_pkg::vreg_t                         pe_vd_o,
  output seq_isa_pkg::vreg_t                         pe_vs1_o,
  output seq_isa_pkg::vreg_t                         pe_vs2_o,
  output seq_ctrl_pkg::vid_mask_t                    pe_haz_vs1_o,
  output seq_ctrl_pkg::vid_mask_t                    pe_haz_vs2_o,
  output seq_ctrl_pkg::vid_mask_t                    pe_haz_vd_o,
  // Completions, one lane per unit
  input  logic [`SEQ_NR_UNITS-1:0]                   done_valid_i,
  input  seq_ctrl_pkg::vid_t [`SEQ_NR_UNITS-1:0]     done_vid_i,
  output logic                                       idle_o
);

  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  vid_mask_t                   running_q, running_d;
  vid_t                        free_vid;
  logic                        free_found;
  unit_e                       tgt_unit;
  qcnt_t [`SEQ_NR_UNITS-1:0]   cnt_q;
  logic  [`SEQ_NR_UNITS-1:0]   cnt_up;
  logic                        unit_free, out_free, issue;

  ////////////////////
  // Issue decision
  ////////////////////

  // Lowest free ID, scanned from the top so the last hit wins
  always_comb begin
    free_vid   = '0;
    free_found = 1'b0;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        free_vid   = vid_t'(i);
        free_found = 1'b1;
      end
    end
  end

  assign tgt_unit  = op_unit(buf_op_i);
  // A completion in this cycle already makes room
  assign unit_free = (cnt_q[tgt_unit] < `SEQ_QUEUE_DEPTH) || done_valid_i[tgt_unit];
  assign out_free  = !pe_valid_o || pe_ready_i;
  assign issue     = buf_valid_i && free_found && unit_free && out_free;

  assign pop_o       = issue;
  assign issue_vid_o = free_vid;
  assign running_o   = running_q;
  assign idle_o      = ~|running_q;

  ////////////////////
  // Running IDs and queue counters
  ////////////////////

  always_comb begin
    running_d = running_q;
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      if (done_valid_i[u]) running_d[done_vid_i[u]] = 1'b0;
      cnt_up[u] = issue && (tgt_unit == unit_e'(u));
    end
    if (issue) running_d[free_vid] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
      cnt_q     <= '0;
    end else begin
      running_q <= running_d;
      // Up and down together leave the count as is
      for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
        if (cnt_up[u] && !done_valid_i[u]) begin
          cnt_q[u] <= cnt_q[u] + 1'b1;
        end else if (!cnt_up[u] && done_valid_i[u]) begin
          cnt_q[u] <= cnt_q[u] - 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Issue register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_valid_o <= 1'b0;
    end else if (issue) begin
      pe_valid_o <= 1'b1;
    end else if (pe_ready_i) begin
      pe_valid_o <= 1'b0;
    end
  end

  // Held while the units stall
  always_ff @(posedge clk_i) begin
    if (issue) begin
      pe_op_o      <= buf_op_i;
      pe_unit_o    <= tgt_unit;
      pe_vid_o     <= free_vid;
      pe_vd_o      <= buf_vd_i;
      pe_vs1_o     <= buf_vs1_i;
      pe_vs2_o     <= buf_vs2_i;
      pe_haz_vs1_o <= haz_vs1_i;
      pe_haz_vs2_o <= haz_vs2_i;
      pe_haz_vd_o  <= haz_vd_i;
    end
  end

endmodule

/* vseq_top.sv */
// Vector instruction sequencer, dispatcher in and unit issue out
// Two cycles minimum from request transfer to issue valid
`timescale 1ns/10ps
`include "seq_params.svh"

module vseq_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Dispatcher
  input  logic                                   req_valid_i,
  input  seq_isa_pkg::vop_e                      req_op_i,
  input  seq_isa_pkg::vreg_t                     req_vd_i,
  input  seq_isa_pkg::vreg_t                     req_vs1_i,
  input  seq_isa_pkg::vreg_t                     req_vs2_i,
  output logic                                   req_ready_o,
  // Units
  output logic                                   pe_valid_o,
  input  logic                                   pe_ready_i,
  output seq_isa_pkg::vop_e                      pe_op_o,
  output seq_isa_pkg::unit_e                     pe_unit_o,
  output seq_ctrl_pkg::vid_t                     pe_vid_o,
  output seq_isa_pkg::vreg_t                     pe_vd_o,
  output seq_isa_pkg::vreg_t                     pe_vs1_o,
  output seq_isa_pkg::vreg_t                     pe_vs2_o,
  output seq_ctrl_pkg::vid_mask_t                pe_haz_vs1_o,
  output seq_ctrl_pkg::vid_mask_t                pe_haz_vs2_o,
  output seq_ctrl_pkg::vid_mask_t                pe_haz_vd_o,
  // Completion and status
  input  logic [`SEQ_NR_UNITS-1:0]               done_valid_i,
  input  seq_ctrl_pkg::vid_t [`SEQ_NR_UNITS-1:0] done_vid_i,
  output logic                                   idle_o
);

  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  // Buffer to tracker and issue control
  logic      buf_valid, buf_pop;
  vop_e      buf_op;
  vreg_t     buf_vd, buf_vs1, buf_vs2;
  // Issue control to tracker
  logic      issue_fire;
  vid_t      issue_vid;
  vid_mask_t running;
  // Tracker to issue control
  vid_mask_t haz_vs1, haz_vs2, haz_vd;

  seq_req_buffer u_req_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_vd_i    (req_vd_i),
    .req_vs1_i   (req_vs1_i),
    .req_vs2_i   (req_vs2_i),
    .req_ready_o (req_ready_o),
    .pop_i       (buf_pop),
    .buf_valid_o (buf_valid),
    .buf_op_o    (buf_op),
    .buf_vd_o    (buf_vd),
    .buf_vs1_o   (buf_vs1),
    .buf_vs2_o   (buf_vs2)
  );

  seq_hazard_tracker u_hazard_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .buf_op_i    (buf_op),
    .buf_vd_i    (buf_vd),
    .buf_vs1_i   (buf_vs1),
    .buf_vs2_i   (buf_vs2),
    .issue_i     (issue_fire),
    .issue_vid_i (issue_vid),
    .running_i   (running),
    .haz_vs1_o   (haz_vs1),
    .haz_vs2_o   (haz_vs2),
    .haz_vd_o    (haz_vd)
  );

  seq_issue_ctrl u_issue_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_valid_i  (buf_valid),
    .buf_op_i     (buf_op),
    .buf_vd_i     (buf_vd),
    .buf_vs1_i    (buf_vs1),
    .buf_vs2_i    (buf_vs2),
    .haz_vs1_i    (haz_vs1),
    .haz_vs2_i    (haz_vs2),
    .haz_vd_i     (haz_vd),
    .pop_o        (buf_pop),
    .issue_vid_o  (issue_vid),
    .running_o    (running),
    .pe_valid_o   (pe_valid_o),
    .pe_ready_i   (pe_ready_i),
    .pe_op_o      (pe_op_o),
    .pe_unit_o    (pe_unit_o),
    .pe_vid_o     (pe_vid_o),
    .pe_vd_o      (pe_vd_o),
    .pe_vs1_o     (pe_vs1_o),
    .pe_vs2_o     (pe_vs2_o),
    .pe_haz_vs1_o (pe_haz_vs1_o),
    .pe_haz_vs2_o (pe_haz_vs2_o),
    .pe_haz_vd_o  (pe_haz_vd_o),
    .done_valid_i (done_valid_i),
    .done_vid_i   (done_vid_i),
    .idle_o       (idle_o)
  );

  // The pop is the issue event
  assign issue_fire = buf_pop;

endmodule

/* tb_vseq.sv */
// Testbench for the vector sequencer, stimulus and expected issue values from vseq_stim.txt
// Instruction records must come in issue order, with masks as seen on the issue edge
// Must run from the project root so that the stim path resolves
`timescale 1ns/10ps
`include "seq_params.svh"

module tb_vseq;

  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  localparam int WAIT_LIMIT   = 200;
  localparam int STALL_CYCLES = 6;

  // One instruction as it should leave the sequencer
  typedef struct packed {
    vop_e      op;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    vid_t      vid;
    vid_mask_t haz_vs1;
    vid_mask_t haz_vs2;
    vid_mask_t haz_vd;
  } issue_exp_t;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                            clk_i = 1'b0;
  logic                            rst_ni;
  logic                            req_valid_i;
  vop_e                            req_op_i;
  vreg_t                           req_vd_i, req_vs1_i, req_vs2_i;
  logic                            req_ready_o;
  logic                            pe_valid_o;
  logic                            pe_ready_i = 1'b0;
  vop_e                            pe_op_o;
  unit_e                           pe_unit_o;
  vid_t                            pe_vid_o;
  vreg_t                           pe_vd_o, pe_vs1_o, pe_vs2_o;
  vid_mask_t                       pe_haz_vs1_o, pe_haz_vs2_o, pe_haz_vd_o;
  logic [`SEQ_NR_UNITS-1:0]        done_valid_i;
  vid_t [`SEQ_NR_UNITS-1:0]        done_vid_i;
  logic                            idle_o;

  ////////////////////
  // Scoreboard state
  ////////////////////

  issue_exp_t  exp_q[$];
  issue_exp_t  mon_exp;
  int          err_cnt   = 0;
  int          fail_cnt  = 0;
  int          sent_cnt  = 0;
  int          taken_cnt = 0;
  // Expected queue fill per unit and IDs in flight
  int          unit_cnt [`SEQ_NR_UNITS];
  vid_mask_t   model_running;
  // Accepted instruction held back by a full unit queue
  logic        pending;
  int          pending_unit;
  logic [15:0] lfsr_q = 16'd11676;
  logic        hold_chk = 1'b0;
  logic [45:0] pe_bundle, held_bundle;

  always #20 clk_i = ~clk_i;

  vseq_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_vd_i     (req_vd_i),
    .req_vs1_i    (req_vs1_i),
    .req_vs2_i    (req_vs2_i),
    .req_ready_o  (req_ready_o),
    .pe_valid_o   (pe_valid_o),
    .pe_ready_i   (pe_ready_i),
    .pe_op_o      (pe_op_o),
    .pe_unit_o    (pe_unit_o),
    .pe_vid_o     (pe_vid_o),
    .pe_vd_o      (pe_vd_o),
    .pe_vs1_o     (pe_vs1_o),
    .pe_vs2_o     (pe_vs2_o),
    .pe_haz_vs1_o (pe_haz_vs1_o),
    .pe_haz_vs2_o (pe_haz_vs2_o),
    .pe_haz_vd_o  (pe_haz_vd_o),
    .done_valid_i (done_valid_i),
    .done_vid_i   (done_vid_i),
    .idle_o       (idle_o)
  );

  // All issue fields, to see them held under back-pressure
  assign pe_bundle = {pe_op_o, pe_unit_o, pe_vid_o, pe_vd_o, pe_vs1_o, pe_vs2_o,
                      pe_haz_vs1_o, pe_haz_vs2_o, pe_haz_vd_o};

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Adds and multiplies share the ALU
  function automatic int unit_for_op(input int op);
    if (op == int'(VLE)) return int'(UNIT_LOAD);
    if (op == int'(VSE)) return int'(UNIT_STORE);
    return int'(UNIT_ALU);
  endfunction

  task automatic report_mismatch(input string what, input int got, input int exp);
    err_cnt++;
    $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
  endtask

  // Unit back-pressure, one LFSR step per ready bit
  always @(posedge clk_i) begin
    if (rst_ni) begin
      lfsr_q = lfsr_step(lfsr_q);
      pe_ready_i <= lfsr_q[0];
    end
  end

  ////////////////////
  // Issue monitor
  ////////////////////

  // Sampled mid-cycle, a handshake seen here completes on the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // A stalled output must stay as it was
      if (hold_chk && (!pe_valid_o || pe_bundle != held_bundle)) begin
        err_cnt++;
        $display("Error at %0d ns: issue outputs changed while pe_ready_i was low", $time);
      end
      hold_chk    <= pe_valid_o && !pe_ready_i;
      held_bundle <= pe_bundle;
      if (pe_valid_o && pe_ready_i) begin
        if (exp_q.size() == 0) begin
          fail_cnt++;
          $display("Instruction ID %0d issued with nothing outstanding", pe_vid_o);
        end else begin
          mon_exp = exp_q.pop_front();
          if (pe_op_o != mon_exp.op) report_mismatch("opcode", pe_op_o, mon_exp.op);
          if (int'(pe_unit_o) != unit_for_op(int'(mon_exp.op))) begin
            report_mismatch("unit", pe_unit_o, unit_for_op(int'(mon_exp.op)));
          end
          if (pe_vid_o != mon_exp.vid) report_mismatch("ID", pe_vid_o, mon_exp.vid);
          if (pe_vd_o != mon_exp.vd) report_mismatch("vd", pe_vd_o, mon_exp.vd);
          if (pe_vs1_o != mon_exp.vs1) report_mismatch("vs1", pe_vs1_o, mon_exp.vs1);
          if (pe_vs2_o != mon_exp.vs2) report_mismatch("vs2", pe_vs2_o, mon_exp.vs2);
          if (pe_haz_vs1_o != mon_exp.haz_vs1) begin
            report_mismatch("vs1 hazard mask", pe_haz_vs1_o, mon_exp.haz_vs1);
          end
          if (pe_haz_vs2_o != mon_exp.haz_vs2) begin
            report_mismatch("vs2 hazard mask", pe_haz_vs2_o, mon_exp.haz_vs2);
          end
          if (pe_haz_vd_o != mon_exp.haz_vd) begin
            report_mismatch("vd hazard mask", pe_haz_vd_o, mon_exp.haz_vd);
          end
          taken_cnt <= taken_cnt + 1;
        end
      end
    end
  end

  ////////////////////
  // Driver tasks
  ////////////////////

  // Until the monitor has seen every sent instruction leave
  task automatic wait_taken();
    int t;
    t = 0;
    while (taken_cnt != sent_cnt && t < WAIT_LIMIT) begin
      @(posedge clk_i);
      t++;
    end
    if (taken_cnt != sent_cnt) begin
      fail_cnt++;
      $display("Timeout: instruction %0d never left the sequencer", sent_cnt - 1);
    end
  endtask

  // Full unit queue, so nothing may issue and the buffer stays occupied
  task automatic check_stall();
    repeat (STALL_CYCLES) begin
      @(negedge clk_i);
      if (pe_valid_o || req_ready_o) begin
        err_cnt++;
        $display("Error at %0d ns: instruction moved on although its unit queue is full",
                 $time);
      end
    end
    @(posedge clk_i);
  endtask

  task automatic send_insn(input int op, input int vd, input int vs1, input int vs2,
                           input int vid, input int h1, input int h2, input int hd);
    issue_exp_t e;
    int         u, t;
    logic       stall;
    logic       accepted;
    u     = unit_for_op(op);
    stall = unit_cnt[u] >= `SEQ_QUEUE_DEPTH;
    req_valid_i <= 1'b1;
    req_op_i    <= vop_e'(op);
    req_vd_i    <= vreg_t'(vd);
    req_vs1_i   <= vreg_t'(vs1);
    req_vs2_i   <= vreg_t'(vs2);
    t        = 0;
    accepted = 1'b0;
    // Ready seen mid-cycle decides the transfer on the following edge
    while (!accepted && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
      t++;
    end
    req_valid_i <= 1'b0;
    if (!accepted) begin
      fail_cnt++;
      $display("Timeout: the sequencer never accepted instruction %0d", sent_cnt);
    end else begin
      e = '{vop_e'(op), vreg_t'(vd), vreg_t'(vs1), vreg_t'(vs2), vid_t'(vid),
            vid_mask_t'(h1), vid_mask_t'(h2), vid_mask_t'(hd)};
      exp_q.push_back(e);
      sent_cnt++;
      model_running[vid] = 1'b1;
      if (stall) begin
        pending      = 1'b1;
        pending_unit = u;
        check_stall();
      end else begin
        unit_cnt[u]++;
        wait_taken();
      end
    end
  endtask

  // One-cycle completion, then idle must follow the IDs still in flight
  task automatic pulse_done(input int unit, input int vid);
    done_valid_i[unit] <= 1'b1;
    done_vid_i[unit]   <= vid_t'(vid);
    @(posedge clk_i);
    done_valid_i <= '0;
    unit_cnt[unit]--;
    model_running[vid] = 1'b0;
    // The freed queue slot lets the held instruction go
    if (pending && pending_unit == unit) begin
      pending = 1'b0;
      unit_cnt[unit]++;
      wait_taken();
    end
    @(negedge clk_i);
    if (!pending && idle_o != (model_running == '0)) begin
      report_mismatch("idle_o", idle_o, model_running == '0);
    end
    @(posedge clk_i);
  endtask

  // Record kinds I and D, lines starting with # are skipped
  task automatic run_records(input int fd);
    int c, n, op, vd, vs1, vs2, vid, h1, h2, hd, unit;
    c = $fgetc(fd);
    while (c != -1 && fail_cnt == 0) begin
      if (c == "I") begin
        n = $fscanf(fd, "%d %d %d %d %d %h %h %h", op, vd, vs1, vs2, vid, h1, h2, hd);
        if (n != 8 || op > 3 || vid >= `SEQ_NR_VINSN) begin
          fail_cnt++;
          $display("Malformed instruction record in vseq_stim.txt");
        end else begin
          send_insn(op, vd, vs1, vs2, vid, h1, h2, hd);
        end
      end else if (c == "D") begin
        n = $fscanf(fd, "%d %d", unit, vid);
        if (n != 2 || unit >= `SEQ_NR_UNITS || vid >= `SEQ_NR_VINSN) begin
          fail_cnt++;
          $display("Malformed completion record in vseq_stim.txt");
        end else begin
          pulse_done(unit, vid);
        end
      end else if (c == "#") begin
        while (c != "\n" && c != -1) c = $fgetc(fd);
      end
      if (c != -1) c = $fgetc(fd);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int fd;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = VADD;
    req_vd_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    done_valid_i  = '0;
    done_vid_i    = '0;
    unit_cnt      = '{default: 0};
    model_running = '0;
    pending       = 1'b0;
    pending_unit  = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // Quiet state straight out of reset
    if (!idle_o) report_mismatch("idle_o after reset", idle_o, 1);
    if (!req_ready_o) report_mismatch("req_ready_o after reset", req_ready_o, 1);
    if (pe_valid_o) report_mismatch("pe_valid_o after reset", pe_valid_o, 0);
    fd = $fopen("vseq_stim.txt", "r");
    if (fd == 0) begin
      fail_cnt++;
      $display("Cannot open vseq_stim.txt, the run must start in the project root");
    end else begin
      run_records(fd);
      $fclose(fd);
    end
    if (fail_cnt == 0 && (pending || taken_cnt != sent_cnt)) begin
      fail_cnt++;
      $display("Stimulus ended with an instruction that never issued");
    end
    if (idle_o != (model_running == '0)) begin
      report_mismatch("idle_o at end", idle_o, model_running == '0);
    end
    $display("Summary: %0d value errors, %0d other failures, %0d instructions issued",
             err_cnt, fail_cnt, taken_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* vseq_stim.txt */
# I op vd vs1 vs2 exp_vid exp_haz_vs1 exp_haz_vs2 exp_haz_vd, op 0 VADD 1 VMUL 2 VLE 3 VSE
# D unit vid, unit 0 ALU 1 LOAD 2 STORE; registers and IDs decimal, masks hex
# Fill the ALU, load and store queues with chained registers
I 0 1 2 3 0 00 00 00
I 2 2 0 0 1 01 01 00
I 1 4 1 2 2 01 02 00
I 3 0 4 0 3 04 00 00
# Third ALU op waits for a retire, and still sees ID 0 on that edge
I 0 4 1 5 4 09 08 04
D 0 0
D 1 1
I 2 5 0 0 0 10 10 00
D 0 2
I 1 2 4 5 1 10 01 00
I 3 0 2 0 2 02 00 00
# Store queue is full now
I 3 0 6 0 5 00 00 00
D 2 3
D 1 0
D 0 4
I 2 6 0 0 0 20 20 00
# Drain everything to idle
D 0 1
D 2 2
D 2 5
D 1 0
# Registers hazarded before are clean again
I 0 2 4 6 0 00 00 00
I 1 4 2 2 1 01 01 00
D 0 0
D 0 1

/* sim.f */
+incdir+.
seq_isa_pkg.sv
seq_ctrl_pkg.sv
seq_req_buffer.sv
seq_hazard_tracker.sv
seq_issue_ctrl.sv
vseq_top.sv
tb_vseq.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sequencer testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_vseq -f sim.f
./obj_dir/Vtb_vseq > sim.log 2>&1
cat sim.log

# The log decides the result
if grep -q "^Test OK$" sim.log; then
  exit 0
fi
exit 1
